// File: src/dma_target_pkg.sv
// Shared definitions of the DMA target: flit layout, header fields, sizes,
// data types and the state encodings of both FSMs

package dma_target_pkg;

  // Data types
  typedef logic [33:0] flit_t;
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  tile_t;
  typedef logic [3:0]  pkt_id_t;
  typedef logic [3:0]  wcount_t;

  typedef enum logic [1:0] {
    PAYLOAD = 2'd0,
    HEADER  = 2'd1,
    LAST    = 2'd2,
    SINGLE  = 2'd3
  } flit_type_t;

  typedef enum logic [1:0] {
    L2R_REQ  = 2'd0,
    L2R_RESP = 2'd1,
    R2L_REQ  = 2'd2,
    R2L_RESP = 2'd3
  } pkt_type_t;

  //////////////////////////////
  // Flit layout
  //////////////////////////////

  // Flit type sits above the 32 content bits
  localparam int FLIT_TYPE_MSB    = 33;
  localparam int FLIT_TYPE_LSB    = 32;
  localparam int FLIT_CONTENT_MSB = 31;
  localparam int FLIT_CONTENT_LSB = 0;

  // Header fields inside the content
  localparam int DEST_MSB     = 31;
  localparam int DEST_LSB     = 27;
  localparam int CLASS_MSB    = 26;
  localparam int CLASS_LSB    = 24;
  localparam int SOURCE_MSB   = 23;
  localparam int SOURCE_LSB   = 19;
  localparam int ID_MSB       = 18;
  localparam int ID_LSB       = 15;
  localparam int PKT_TYPE_MSB = 14;
  localparam int PKT_TYPE_LSB = 13;
  localparam int LAST_BIT     = 12;
  localparam int SIZE_MSB     = 11;
  localparam int SIZE_LSB     = 0;

  localparam logic [2:0] CLASS_DMA = 3'd2;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int NOC_PACKET_SIZE = 16;
  localparam int FLIT_BUF_DEPTH  = NOC_PACKET_SIZE;
  // Header and remote address take two flits of a response
  localparam int MAX_READ_WORDS  = NOC_PACKET_SIZE - 2;
  localparam int READ_FIFO_DEPTH = 3;

  // Request controller states
  typedef enum logic [2:0] {
    REQ_IDLE,
    REQ_L2R_ADDR,
    REQ_L2R_DATA,
    REQ_R2L_LADDR,
    REQ_R2L_RADDR,
    REQ_R2L_READ,
    REQ_DISCARD
  } req_state_e;

  // Response generator states
  typedef enum logic [2:0] {
    RSP_IDLE,
    RSP_ACK,
    RSP_HDR,
    RSP_RADDR,
    RSP_DATA
  } resp_state_e;

endpackage

// File: src/dma_flit_buffer.sv
`timescale 1ns/1ns

// Flit FIFO between the NoC input and the request controller
// Holds a full packet so the NoC is not stalled by slow bus transfers

module dma_flit_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_target_pkg::flit_t in_flit,
  input  logic                  in_valid,
  output logic                  in_ready,
  output dma_target_pkg::flit_t out_flit,
  output logic                  out_valid,
  input  logic                  out_ready
);
  import dma_target_pkg::*;

  // Flit storage
  flit_t mem [FLIT_BUF_DEPTH];

  logic [$clog2(FLIT_BUF_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FLIT_BUF_DEPTH)-1:0] rd_ptr;
  // One extra bit so a full buffer can be told from an empty one
  logic [$clog2(FLIT_BUF_DEPTH):0]   count;

  logic wr_en;
  logic rd_en;

  assign in_ready  = (count != FLIT_BUF_DEPTH);
  assign out_valid = (count != 0);
  assign out_flit  = mem[rd_ptr];

  assign wr_en = in_valid & in_ready;
  assign rd_en = out_valid & out_ready;

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == FLIT_BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == FLIT_BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves the count as it is
      if (wr_en & ~rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en & ~wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_flit;
    end
  end

endmodule

// File: src/dma_request_ctrl.sv
`timescale 1ns/1ns

// Decodes DMA request packets from the flit buffer, runs the local bus
// writes and reads and hands response commands to the response generator

module dma_request_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  dma_target_pkg::flit_t   buf_flit,
  input  logic                    buf_valid,
  output logic                    buf_ready,
  output logic                    mem_sel,
  output logic                    mem_write,
  output dma_target_pkg::addr_t   mem_addr,
  output dma_target_pkg::word_t   mem_wdata,
  input  dma_target_pkg::word_t   mem_rdata,
  input  logic                    mem_ready,
  output logic                    push,
  output dma_target_pkg::word_t   push_data,
  input  logic                    full,
  output logic                    cmd_valid,
  input  logic                    cmd_ready,
  output logic                    cmd_read,
  output dma_target_pkg::tile_t   cmd_dest,
  output dma_target_pkg::pkt_id_t cmd_id,
  output dma_target_pkg::wcount_t cmd_words,
  output dma_target_pkg::addr_t   cmd_raddr
);
  import dma_target_pkg::*;

  req_state_e state;
  req_state_e state_nxt;

  // Fields latched from the request header
  tile_t   src_tile;
  pkt_id_t pkt_id;
  wcount_t words;
  logic    end_of_req;

  // Local word address, steps by 4 per completed transfer
  addr_t   addr;

  // Write stage between buffer and bus
  logic    wr_sel;
  word_t   wr_data;
  // LAST flit of the L2R packet already taken
  logic    last_taken;

  // Completed reads of the current R2L request
  wcount_t rd_cnt;

  logic [SIZE_MSB-SIZE_LSB:0] hdr_size;
  logic flit_last;
  logic take;
  logic wr_done;
  logic rd_done;

  assign hdr_size  = buf_flit[SIZE_MSB:SIZE_LSB];
  assign flit_last = (buf_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB] == LAST) |
                     (buf_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB] == SINGLE);
  assign take      = buf_valid & buf_ready;
  assign wr_done   = wr_sel & mem_ready;
  assign rd_done   = (state == REQ_R2L_READ) & mem_sel & mem_ready;

  //////////////////////////////
  // Bus and FIFO side
  //////////////////////////////

  // Reads stop as soon as the FIFO reports full
  assign mem_sel   = wr_sel | ((state == REQ_R2L_READ) & ~full);
  assign mem_write = wr_sel;
  assign mem_addr  = addr;
  assign mem_wdata = wr_data;

  assign push      = rd_done;
  assign push_data = mem_rdata;

  // Command fields, remote address straight from the R2L address flit
  assign cmd_read  = (state == REQ_R2L_RADDR);
  assign cmd_dest  = src_tile;
  assign cmd_id    = pkt_id;
  assign cmd_words = words;
  assign cmd_raddr = buf_flit[FLIT_CONTENT_MSB:FLIT_CONTENT_LSB];

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_nxt = state;
    buf_ready = 1'b0;
    cmd_valid = 1'b0;
    case (state)
      REQ_IDLE: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          case (buf_flit[PKT_TYPE_MSB:PKT_TYPE_LSB])
            L2R_REQ: state_nxt = REQ_L2R_ADDR;
            R2L_REQ: state_nxt = REQ_R2L_LADDR;
            // Unknown type, a single-flit packet is gone already
            default: state_nxt = flit_last ? REQ_IDLE : REQ_DISCARD;
          endcase
        end
      end
      REQ_L2R_ADDR: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          state_nxt = REQ_L2R_DATA;
        end
      end
      REQ_L2R_DATA: begin
        // Next word may enter the write stage while the current one completes
        buf_ready = (~wr_sel | mem_ready) & ~last_taken;
        // All words written, acknowledge only if requested
        if (last_taken & ~wr_sel) begin
          cmd_valid = end_of_req;
          if (~end_of_req | cmd_ready) begin
            state_nxt = REQ_IDLE;
          end
        end
      end
      REQ_R2L_LADDR: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          state_nxt = REQ_R2L_RADDR;
        end
      end
      REQ_R2L_RADDR: begin
        // Read command goes out together with the remote address flit
        cmd_valid = buf_valid;
        buf_ready = cmd_ready;
        if (take) begin
          state_nxt = REQ_R2L_READ;
        end
      end
      REQ_R2L_READ: begin
        if (rd_done && rd_cnt == words - 4'd1) begin
          state_nxt = REQ_IDLE;
        end
      end
      REQ_DISCARD: begin
        buf_ready = 1'b1;
        if (buf_valid & flit_last) begin
          state_nxt = REQ_IDLE;
        end
      end
      default: state_nxt = REQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= REQ_IDLE;
      wr_sel     <= 1'b0;
      last_taken <= 1'b0;
      rd_cnt     <= '0;
    end else begin
      state <= state_nxt;
      if (state == REQ_L2R_DATA && take) begin
        wr_sel <= 1'b1;
      end else if (wr_done) begin
        wr_sel <= 1'b0;
      end
      // An address flit typed LAST means a write without payload
      if (take && (state == REQ_L2R_ADDR || state == REQ_L2R_DATA)) begin
        last_taken <= flit_last;
      end else if (state == REQ_IDLE) begin
        last_taken <= 1'b0;
      end
      if (state == REQ_R2L_RADDR) begin
        rd_cnt <= '0;
      end else if (rd_done) begin
        rd_cnt <= rd_cnt + 4'd1;
      end
    end
  end

  // Header fields, address and write data
  always_ff @(posedge clk) begin
    if (state == REQ_IDLE && buf_valid) begin
      src_tile   <= buf_flit[SOURCE_MSB:SOURCE_LSB];
      pkt_id     <= buf_flit[ID_MSB:ID_LSB];
      end_of_req <= buf_flit[LAST_BIT];
      // Word count kept within one response packet
      if (hdr_size == '0) begin
        words <= wcount_t'(1);
      end else if (hdr_size > MAX_READ_WORDS) begin
        words <= wcount_t'(MAX_READ_WORDS);
      end else begin
        words <= wcount_t'(hdr_size);
      end
    end
    if (take && (state == REQ_L2R_ADDR || state == REQ_R2L_LADDR)) begin
      addr <= buf_flit[FLIT_CONTENT_MSB:FLIT_CONTENT_LSB];
    end else if (wr_done || rd_done) begin
      addr <= addr + 32'd4;
    end
    if (state == REQ_L2R_DATA && take) begin
      wr_data <= buf_flit[FLIT_CONTENT_MSB:FLIT_CONTENT_LSB];
    end
  end

endmodule

// File: src/dma_read_fifo.sv
`timescale 1ns/1ns

// Small read-data FIFO between the local bus reads and the NoC response
// Shift register with a one-hot occupancy marker, entry 0 is the head

module dma_read_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  dma_target_pkg::word_t push_data,
  output logic                  full,
  input  logic                  pop,
  output logic                  rd_valid,
  output dma_target_pkg::word_t rd_data
);
  import dma_target_pkg::*;

  word_t data [READ_FIFO_DEPTH];
  // Entries moved one step towards the head
  word_t shifted [READ_FIFO_DEPTH];

  // Marks the next write position, bit 0 set means empty
  logic [READ_FIFO_DEPTH:0] pos;

  // Both flags come from the register only, pop never reaches full
  assign rd_valid = ~pos[0];
  assign full     = pos[READ_FIFO_DEPTH];
  assign rd_data  = data[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= (READ_FIFO_DEPTH + 1)'(1);
    end else if (push & ~pop) begin
      pos <= pos << 1;
    end else if (pop & ~push) begin
      pos <= pos >> 1;
    end
  end

  always_comb begin
    for (int i = 0; i < READ_FIFO_DEPTH - 1; i++) begin
      shifted[i] = data[i + 1];
    end
    shifted[READ_FIFO_DEPTH - 1] = data[READ_FIFO_DEPTH - 1];
  end

  // On a pop the write position moves down by one entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < READ_FIFO_DEPTH; i++) begin
      if (push && (pop ? pos[i + 1] : pos[i])) begin
        data[i] <= push_data;
      end else if (pop) begin
        data[i] <= shifted[i];
      end
    end
  end

endmodule

// File: src/dma_response_gen.sv
`timescale 1ns/1ns

// Builds the response packets of the DMA target, either a single-flit L2R
// acknowledgement or an R2L response fed from the read FIFO

module dma_response_gen #(
  parameter dma_target_pkg::tile_t tile_id = 5'd0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  logic                    cmd_read,
  input  dma_target_pkg::tile_t   cmd_dest,
  input  dma_target_pkg::pkt_id_t cmd_id,
  input  dma_target_pkg::wcount_t cmd_words,
  input  dma_target_pkg::addr_t   cmd_raddr,
  output logic                    pop,
  input  logic                    rd_valid,
  input  dma_target_pkg::word_t   rd_data,
  output dma_target_pkg::flit_t   noc_out_flit,
  output logic                    noc_out_valid,
  input  logic                    noc_out_ready
);
  import dma_target_pkg::*;

  resp_state_e state;

  // Latched command
  tile_t   dest;
  pkt_id_t id;
  wcount_t words;
  addr_t   raddr;

  // Data flits sent so far
  wcount_t cnt;
  logic    final_word;

  assign cmd_ready  = (state == RSP_IDLE);
  assign final_word = (cnt == words - 4'd1);

  //////////////////////////////
  // Flit assembly
  //////////////////////////////

  // Everything comes from registers, so a stalled flit holds still
  always_comb begin
    noc_out_flit  = '0;
    noc_out_valid = 1'b0;
    pop           = 1'b0;
    case (state)
      RSP_ACK: begin
        noc_out_valid                                = 1'b1;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB]    = SINGLE;
        noc_out_flit[DEST_MSB:DEST_LSB]              = dest;
        noc_out_flit[CLASS_MSB:CLASS_LSB]            = CLASS_DMA;
        noc_out_flit[ID_MSB:ID_LSB]                  = id;
        noc_out_flit[PKT_TYPE_MSB:PKT_TYPE_LSB]      = L2R_RESP;
      end
      RSP_HDR: begin
        noc_out_valid                                = 1'b1;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB]    = HEADER;
        noc_out_flit[DEST_MSB:DEST_LSB]              = dest;
        noc_out_flit[CLASS_MSB:CLASS_LSB]            = CLASS_DMA;
        noc_out_flit[SOURCE_MSB:SOURCE_LSB]          = tile_id;
        noc_out_flit[ID_MSB:ID_LSB]                  = id;
        noc_out_flit[PKT_TYPE_MSB:PKT_TYPE_LSB]      = R2L_RESP;
        // Whole response always fits one packet
        noc_out_flit[LAST_BIT]                       = 1'b1;
        noc_out_flit[SIZE_MSB:SIZE_LSB]              = 12'(words);
      end
      RSP_RADDR: begin
        noc_out_valid                                = 1'b1;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB]    = PAYLOAD;
        noc_out_flit[FLIT_CONTENT_MSB:FLIT_CONTENT_LSB] = raddr;
      end
      RSP_DATA: begin
        noc_out_valid                                = rd_valid;
        noc_out_flit[FLIT_TYPE_MSB:FLIT_TYPE_LSB]    = final_word ? LAST : PAYLOAD;
        noc_out_flit[FLIT_CONTENT_MSB:FLIT_CONTENT_LSB] = rd_data;
        pop                                          = rd_valid & noc_out_ready;
      end
      default: ;
    endcase
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RSP_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        RSP_IDLE: begin
          if (cmd_valid) begin
            state <= cmd_read ? RSP_HDR : RSP_ACK;
          end
        end
        RSP_ACK: begin
          if (noc_out_ready) begin
            state <= RSP_IDLE;
          end
        end
        RSP_HDR: begin
          if (noc_out_ready) begin
            state <= RSP_RADDR;
          end
        end
        RSP_RADDR: begin
          cnt <= '0;
          if (noc_out_ready) begin
            state <= RSP_DATA;
          end
        end
        RSP_DATA: begin
          if (pop) begin
            cnt <= cnt + 4'd1;
            if (final_word) begin
              state <= RSP_IDLE;
            end
          end
        end
        default: state <= RSP_IDLE;
      endcase
    end
  end

  // Command payload, taken on the handshake
  always_ff @(posedge clk) begin
    if (cmd_valid & cmd_ready) begin
      dest  <= cmd_dest;
      id    <= cmd_id;
      words <= cmd_words;
      raddr <= cmd_raddr;
    end
  end

endmodule

// File: src/dma_target_top.sv
`timescale 1ns/1ns

// DMA target of a NoC tile: flit buffer, request controller, read FIFO and
// response generator between the NoC ports and the local memory bus

module dma_target_top #(
  parameter dma_target_pkg::tile_t tile_id = 5'd0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_target_pkg::flit_t noc_in_flit,
  input  logic                  noc_in_valid,
  output logic                  noc_in_ready,
  output dma_target_pkg::flit_t noc_out_flit,
  output logic                  noc_out_valid,
  input  logic                  noc_out_ready,
  output logic                  mem_sel,
  output logic                  mem_write,
  output dma_target_pkg::addr_t mem_addr,
  output dma_target_pkg::word_t mem_wdata,
  input  dma_target_pkg::word_t mem_rdata,
  input  logic                  mem_ready
);
  import dma_target_pkg::*;

  // Buffer to controller
  flit_t   buf_flit;
  logic    buf_valid;
  logic    buf_ready;

  // Controller to read FIFO
  logic    push;
  word_t   push_data;
  logic    full;

  // Read FIFO to response generator
  logic    pop;
  logic    rd_valid;
  word_t   rd_data;

  // Response commands
  logic    cmd_valid;
  logic    cmd_ready;
  logic    cmd_read;
  tile_t   cmd_dest;
  pkt_id_t cmd_id;
  wcount_t cmd_words;
  addr_t   cmd_raddr;

  dma_flit_buffer i_dma_flit_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  dma_request_ctrl i_dma_request_ctrl (
    .clk       (clk),
    .rst       (rst),
    .buf_flit  (buf_flit),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready),
    .mem_sel   (mem_sel),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_read  (cmd_read),
    .cmd_dest  (cmd_dest),
    .cmd_id    (cmd_id),
    .cmd_words (cmd_words),
    .cmd_raddr (cmd_raddr)
  );

  dma_read_fifo i_dma_read_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .pop       (pop),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  dma_response_gen #(
    .tile_id (tile_id)
  ) i_dma_response_gen (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_read      (cmd_read),
    .cmd_dest      (cmd_dest),
    .cmd_id        (cmd_id),
    .cmd_words     (cmd_words),
    .cmd_raddr     (cmd_raddr),
    .pop           (pop),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready)
  );

endmodule

// File: sim/dma_target_chk.sv
`timescale 1ns/1ns

// Protocol checks on the NoC output port and the local memory bus
// Bound to the DMA target top level

module dma_target_chk (
  input logic                  clk,
  input logic                  rst,
  input dma_target_pkg::flit_t noc_out_flit,
  input logic                  noc_out_valid,
  input logic                  noc_out_ready,
  input logic                  mem_sel,
  input logic                  mem_write,
  input dma_target_pkg::addr_t mem_addr,
  input dma_target_pkg::word_t mem_wdata,
  input logic                  mem_ready
);

  // Number of failed assertions so far
  int assert_fails;

  initial assert_fails = 0;

  // A stalled output flit must not change or disappear
  out_held: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out_flit))
  else begin
    $error("NoC output flit changed while stalled");
    assert_fails++;
  end

  // Word transfers only
  addr_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_sel |-> mem_addr[1:0] == 2'b00)
  else begin
    $error("Memory address not word aligned");
    assert_fails++;
  end

  // Bus request held during wait states
  bus_held: assert property (@(posedge clk) disable iff (rst)
    mem_sel && !mem_ready |=> $stable(mem_addr) && $stable(mem_write) && $stable(mem_wdata))
  else begin
    $error("Memory bus request changed during a wait state");
    assert_fails++;
  end

endmodule

bind dma_target_top dma_target_chk i_dma_target_chk (
  .clk           (clk),
  .rst           (rst),
  .noc_out_flit  (noc_out_flit),
  .noc_out_valid (noc_out_valid),
  .noc_out_ready (noc_out_ready),
  .mem_sel       (mem_sel),
  .mem_write     (mem_write),
  .mem_addr      (mem_addr),
  .mem_wdata     (mem_wdata),
  .mem_ready     (mem_ready)
);

// File: sim/tb_dma_target.sv
`timescale 1ns/1ns

// Testbench of the DMA target with clock, reset, a local memory model with wait
// states, a NoC driver and receiver and directed tests of writes, reads and discard

module tb_dma_target;
  import dma_target_pkg::*;

  // Tile of the DUT and of the requesting tile
  localparam tile_t own_tile = 5'd9;
  localparam tile_t req_tile = 5'd3;
  // All tests together take well under a thousand cycles
  localparam int max_cycles = 20000;

  logic  clk;
  logic  rst;
  flit_t noc_in_flit;
  logic  noc_in_valid;
  logic  noc_in_ready;
  flit_t noc_out_flit;
  logic  noc_out_valid;
  logic  noc_out_ready;
  logic  mem_sel;
  logic  mem_write;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic  mem_ready;

  // Memory model of 256 words
  word_t mem [256];
  int    write_cnt;
  // Random bus wait states and random NoC output stalls
  logic  mem_wait;
  logic  out_stall;

  // Request packet being sent and the data words expected back
  flit_t pkt [NOC_PACKET_SIZE];
  int    pkt_len;
  word_t exp_words [NOC_PACKET_SIZE];

  int    cycle_cnt;

  dma_target_top #(
    .tile_id (own_tile)
  ) i_dma_target_top (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .mem_sel       (mem_sel),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .mem_ready     (mem_ready)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Memory model
  //////////////////////////////

  assign mem_rdata = mem[mem_addr[9:2]];

  // Write taken mid-cycle where the bus is stable
  always @(negedge clk) begin
    if (!rst && mem_sel && mem_ready && mem_write) begin
      mem[mem_addr[9:2]] = mem_wdata;
      write_cnt = write_cnt + 1;
    end
  end

  // Wait states and back-pressure change just after each rising edge
  always @(posedge clk) begin
    #1;
    mem_ready     = mem_wait ? ($urandom_range(3) != 0) : 1'b1;
    noc_out_ready = out_stall ? ($urandom_range(1) == 1) : 1'b1;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation timeout");
  end

  // Stop at the first failed protocol assertion
  always @(i_dma_target_top.i_dma_target_chk.assert_fails) begin
    if (i_dma_target_top.i_dma_target_chk.assert_fails != 0) begin
      $display("Protocol assertion failed at %0t ns", $time);
      $display("TESTBENCH FAILED");
      $fatal(1, "protocol assertion failure");
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic compare(input logic [33:0] actual, input logic [33:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic flit_t make_flit(logic [1:0] ftype, word_t content);
    return {ftype, content};
  endfunction

  function automatic flit_t make_header(tile_t dest, tile_t src, pkt_id_t id,
                                        logic [1:0] ptype, logic last, int size);
    flit_t f;
    f = '0;
    f[FLIT_TYPE_MSB:FLIT_TYPE_LSB] = HEADER;
    f[DEST_MSB:DEST_LSB]           = dest;
    f[CLASS_MSB:CLASS_LSB]         = CLASS_DMA;
    f[SOURCE_MSB:SOURCE_LSB]       = src;
    f[ID_MSB:ID_LSB]               = id;
    f[PKT_TYPE_MSB:PKT_TYPE_LSB]   = ptype;
    f[LAST_BIT]                    = last;
    f[SIZE_MSB:SIZE_LSB]           = size[11:0];
    return f;
  endfunction

  // Ready sampled mid-cycle and the flit moves at the next edge
  task automatic send_flit(input flit_t f);
    logic done;
    noc_in_flit  = f;
    noc_in_valid = 1'b1;
    done         = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = noc_in_ready;
      tick();
    end
    noc_in_valid = 1'b0;
  endtask

  task automatic send_packet();
    for (int i = 0; i < pkt_len; i++) begin
      send_flit(pkt[i]);
    end
  endtask

  task automatic recv_flit(output flit_t f);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (noc_out_valid && noc_out_ready) begin
        f    = noc_out_flit;
        done = 1'b1;
      end
      tick();
    end
  endtask

  task automatic expect_silence(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      compare(noc_out_valid, 1'b0, "unexpected response flit");
      tick();
    end
  endtask

  // L2R request of n words followed by the memory check and the ack or silence
  task automatic l2r_write(input int n, input addr_t base, input pkt_id_t id,
                           input logic last);
    int    target;
    flit_t f;
    pkt[0] = make_header(own_tile, req_tile, id, L2R_REQ, last, n);
    pkt[1] = make_flit(PAYLOAD, base);
    for (int i = 0; i < n; i++) begin
      exp_words[i] = $urandom();
      pkt[i + 2]   = make_flit((i == n - 1) ? LAST : PAYLOAD, exp_words[i]);
    end
    pkt_len = n + 2;
    target  = write_cnt + n;
    send_packet();
    while (write_cnt < target) begin
      tick();
    end
    for (int i = 0; i < n; i++) begin
      compare(mem[base[9:2] + i], exp_words[i], $sformatf("memory word %0d of write", i));
    end
    if (last) begin
      recv_flit(f);
      compare(f[FLIT_TYPE_MSB:FLIT_TYPE_LSB], SINGLE, "ack flit type");
      compare(f[DEST_MSB:DEST_LSB], req_tile, "ack dest");
      compare(f[CLASS_MSB:CLASS_LSB], CLASS_DMA, "ack class");
      compare(f[ID_MSB:ID_LSB], id, "ack id");
      compare(f[PKT_TYPE_MSB:PKT_TYPE_LSB], L2R_RESP, "ack packet type");
    end else begin
      expect_silence(100);
    end
  endtask

  // R2L request of n words from fresh random memory contents
  task automatic r2l_read(input int n, input addr_t laddr, input addr_t raddr,
                          input pkt_id_t id);
    flit_t f;
    for (int i = 0; i < n; i++) begin
      exp_words[i]         = $urandom();
      mem[laddr[9:2] + i] = exp_words[i];
    end
    pkt[0]  = make_header(own_tile, req_tile, id, R2L_REQ, 1'b1, n);
    pkt[1]  = make_flit(PAYLOAD, laddr);
    pkt[2]  = make_flit(LAST, raddr);
    pkt_len = 3;
    send_packet();
    recv_flit(f);
    compare(f[FLIT_TYPE_MSB:FLIT_TYPE_LSB], HEADER, "response flit type");
    compare(f[DEST_MSB:DEST_LSB], req_tile, "response dest");
    compare(f[CLASS_MSB:CLASS_LSB], CLASS_DMA, "response class");
    compare(f[SOURCE_MSB:SOURCE_LSB], own_tile, "response source");
    compare(f[ID_MSB:ID_LSB], id, "response id");
    compare(f[PKT_TYPE_MSB:PKT_TYPE_LSB], R2L_RESP, "response packet type");
    compare(f[LAST_BIT], 1'b1, "response last bit");
    compare(f[SIZE_MSB:SIZE_LSB], n, "response size");
    recv_flit(f);
    compare(f, make_flit(PAYLOAD, raddr), "remote address flit");
    for (int i = 0; i < n; i++) begin
      recv_flit(f);
      compare(f, make_flit((i == n - 1) ? LAST : PAYLOAD, exp_words[i]),
              $sformatf("read data flit %0d", i));
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    @(negedge clk);
    compare(noc_out_valid, 1'b0, "noc_out_valid after reset");
    compare(mem_sel, 1'b0, "mem_sel after reset");
    compare(noc_in_ready, 1'b1, "noc_in_ready after reset");
    tick();
  endtask

  task automatic test_write_ack();
    l2r_write(6, 32'h0000_0040, 4'd2, 1'b1);
  endtask

  task automatic test_write_silent();
    l2r_write(5, 32'h0000_0100, 4'd4, 1'b0);
  endtask

  task automatic test_read();
    int n;
    n = $urandom_range(MAX_READ_WORDS, 1);
    r2l_read(n, 32'h0000_0180, 32'h4000_0a00, 4'd9);
  endtask

  // FIFO fills while the output stalls so the reads pause and resume
  task automatic test_read_backpressure();
    mem_wait  = 1'b1;
    out_stall = 1'b1;
    r2l_read(MAX_READ_WORDS, 32'h0000_0200, 32'h8000_1000, 4'd11);
    mem_wait  = 1'b0;
    out_stall = 1'b0;
  endtask

  task automatic test_discard();
    int    start;
    word_t untouched;
    // Word that the discarded packet's second flit would point at
    untouched = mem[8'hb0];
    start     = write_cnt;
    pkt[0]    = make_header(own_tile, req_tile, 4'd5, R2L_RESP, 1'b1, 3);
    pkt[1]    = make_flit(PAYLOAD, 32'h0000_02c0);
    pkt[2]    = make_flit(PAYLOAD, 32'hdead_0001);
    pkt[3]    = make_flit(LAST, 32'hdead_0002);
    pkt_len   = 4;
    send_packet();
    l2r_write(4, 32'h0000_0300, 4'd7, 1'b1);
    compare(write_cnt - start, 4, "write count after discard");
    compare(mem[8'hb0], untouched, "word at discarded address");
  endtask

  initial begin
    void'($urandom(32'h7318));
    clk           = 1'b0;
    rst           = 1'b1;
    noc_in_flit   = '0;
    noc_in_valid  = 1'b0;
    noc_out_ready = 1'b1;
    mem_ready     = 1'b1;
    mem_wait      = 1'b0;
    out_stall     = 1'b0;
    write_cnt     = 0;
    pkt_len       = 0;
    // Fill pattern from the whole word index
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h6b00_0000 ^ (i * 32'h0001_0203);
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset();
    test_write_ack();
    test_write_silent();
    test_read();
    test_read_backpressure();
    test_discard();

    if (i_dma_target_top.i_dma_target_chk.assert_fails == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times",
               i_dma_target_top.i_dma_target_chk.assert_fails);
      $display("TESTBENCH FAILED");
      $fatal(1, "protocol assertion failures");
    end
  end

endmodule

// File: src.f
src/dma_target_pkg.sv
src/dma_flit_buffer.sv
src/dma_request_ctrl.sv
src/dma_read_fifo.sv
src/dma_response_gen.sv
src/dma_target_top.sv
sim/dma_target_chk.sv
sim/tb_dma_target.sv
